/* build.f */
+incdir+.
psx_loader_pkg.sv
download_decoder.sv
download_packer.sv
ram_write_arbiter.sv
media_mount_tracker.sv
psx_loader_top.sv
psx_loader_properties.sv
tb_psx_loader.sv

/* Makefile */
TOP := tb_psx_loader

.PHONY: all lint clean

# Build, run, and pass only if the pass line appears
all: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx 'Verification passed'

obj_dir/V$(TOP): build.f $(wildcard *.sv *.svh)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f build.f

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f build.f

clean:
	rm -rf obj_dir

/* tb_psx_loader.sv */
/*
 Testbench of the loader front end. A table of downloads, mounts,
 backup controls and system writes is applied row by row. The host
 model honours host_wait, and the RAM model answers with random
 ready and logs every accepted write for in-order comparison.
*/
`timescale 1ns/10ps
`default_nettype none
`include "psx_loader_macros.svh"

module tb_psx_loader;
	import psx_loader_pkg::*;

	typedef enum logic [2:0] {
		OP_DL, OP_MOUNT, OP_BKLOAD, OP_BKSAVE, OP_AUTOSAVE, OP_SYS
	} op_e;

	// One table row, stimulus first and expected state after
	// exp_cards bit 0 is card 1, bit 1 card 2
	typedef struct packed {
		op_e        op;
		dl_index_t  arg;
		logic [7:0] words;
		ram_word_t  value;
		logic       exp_present;
		logic       exp_from_card;
		cd_size_t   exp_size;
		logic [1:0] exp_cards;
		logic [1:0] exp_exe;
		logic [1:0] exp_c1;
		logic [1:0] exp_c2;
		logic [1:0] exp_save;
	} test_row_s;

	localparam int        NUM_ROWS = 13;
	localparam ram_addr_t SYS_ADDR = 27'h012_3450;

	logic       clk_1x;
	logic       rst;
	host_dl_s   host_dl;
	ram_wr_s    sys_wr;
	ram_wr_s    ram_wr;
	mount_s     mount;
	half_word_t sbi_key;
	cd_size_t   cd_size;
	logic       host_wait, sys_valid, sys_ready, ram_valid, exe_start;
	logic       bk_load, bk_save, bk_autosave, osd_status;
	logic       cd_present, cd_from_card, card1_available, card2_available;
	logic       card1_load, card2_load, card_save;
	logic       ram_ready = 1'b0;

	test_row_s   rows [NUM_ROWS];
	ram_wr_s     ram_log[$];
	int          counts [4];
	int          snap [4];
	int          errors;
	int          checks;
	int          cycles;
	int          limit = 1000;
	integer      seed = 32'h72f1_4eb7;
	logic [31:0] rand_word;

	psx_loader_top uut (.*);

	initial begin
		clk_1x = 1'b0;
		forever #20 clk_1x = ~clk_1x;
	end

	always @(posedge clk_1x) begin
		cycles++;
		if (cycles > limit) begin
			$display("Timeout: run did not finish within %0d cycles", limit);
			$display("Verification failed");
			$finish;
		end
	end

	// ==============================
	// RAM model and pulse counters
	// ==============================
	always @(posedge clk_1x) begin
		#2;
		rand_word = $random(seed);
		ram_ready = rand_word[0];
	end

	// Sampled mid-cycle, where all outputs are settled
	always @(negedge clk_1x) begin
		if (ram_valid && ram_ready) ram_log.push_back(ram_wr);
		if (exe_start) counts[0]++;
		if (card1_load) counts[1]++;
		if (card2_load) counts[2]++;
		if (card_save) counts[3]++;
	end

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic next_cycle();
		@(posedge clk_1x);
		#2;
	endtask

	function automatic ram_word_t word_of(input ram_word_t base, input int k);
		return base + ram_word_t'(k) * 32'h0001_0003;
	endfunction

	function automatic logic is_ram_index(input dl_index_t idx);
		return idx == `PSX_IDX_BIOS || idx == `PSX_IDX_EXE || idx[5:0] == `PSX_IDX_CD;
	endfunction

	function automatic ram_addr_t region_base_of(input dl_index_t idx);
		if (idx == `PSX_IDX_BIOS) return `PSX_BIOS_BASE;
		if (idx == `PSX_IDX_EXE) return `PSX_EXE_BASE;
		return '0;
	endfunction

	// Host sends low then high half of each word, then waits out the stall
	task automatic run_download(input dl_index_t idx, input int words, input ram_word_t base);
		ram_word_t word;
		host_dl.download = 1'b1;
		host_dl.index = idx;
		host_dl.wr = 1'b0;
		repeat (2) next_cycle();
		for (int k = 0; k < words; k++) begin
			word = word_of(base, k);
			host_dl.addr = ram_addr_t'(4 * k);
			host_dl.data = word[15:0];
			host_dl.wr = 1'b1;
			next_cycle();
			host_dl.addr[1] = 1'b1;
			host_dl.data = word[31:16];
			next_cycle();
			host_dl.wr = 1'b0;
			while (host_wait) next_cycle();
		end
		host_dl.download = 1'b0;
	endtask

	task automatic apply_row(input test_row_s r);
		case (r.op)
			OP_DL: run_download(r.arg, int'(r.words), r.value);
			OP_MOUNT: begin
				mount.mounted = 4'b0001 << r.arg[1:0];
				mount.size = 64'(r.value);
				next_cycle();
				mount = '0;
			end
			OP_BKLOAD: begin
				bk_load = 1'b1;
				next_cycle();
				bk_load = 1'b0;
			end
			OP_BKSAVE: begin
				bk_save = 1'b1;
				next_cycle();
				bk_save = 1'b0;
			end
			OP_AUTOSAVE: begin
				bk_autosave = 1'b1;
				osd_status = 1'b1;
				next_cycle();
				osd_status = 1'b0;
				bk_autosave = 1'b0;
			end
			default: begin
				sys_wr.addr = SYS_ADDR;
				sys_wr.data = r.value;
				sys_wr.be = 4'b0101;
				sys_valid = 1'b1;
				@(negedge clk_1x);
				while (!sys_ready) @(negedge clk_1x);
				next_cycle();
				sys_valid = 1'b0;
			end
		endcase
		repeat (6) next_cycle();
	endtask

	task automatic check_row(input int n, input test_row_s r);
		int        err_before;
		ram_wr_s   w;
		ram_wr_s   got;
		ram_wr_s   expect_q[$];
		ram_word_t last;
		err_before = errors;
		if (r.op == OP_DL && is_ram_index(r.arg)) begin
			for (int k = 0; k < int'(r.words); k++) begin
				w.addr = region_base_of(r.arg) + ram_addr_t'(4 * k);
				w.data = word_of(r.value, k);
				w.be = 4'hF;
				expect_q.push_back(w);
			end
		end
		if (r.op == OP_SYS) begin
			w.addr = SYS_ADDR;
			w.data = r.value;
			w.be = 4'b0101;
			expect_q.push_back(w);
		end
		check("ram write count", 64'(ram_log.size()), 64'(expect_q.size()));
		while (ram_log.size() > 0 && expect_q.size() > 0) begin
			got = ram_log.pop_front();
			w = expect_q.pop_front();
			check("ram_wr.addr", 64'(got.addr), 64'(w.addr));
			check("ram_wr.data", 64'(got.data), 64'(w.data));
			check("ram_wr.be", 64'(got.be), 64'(w.be));
		end
		ram_log.delete();
		if (r.op == OP_DL && r.arg == `PSX_IDX_SBI) begin
			last = word_of(r.value, int'(r.words) - 1);
			check("sbi_key", 64'(sbi_key), 64'(last[31:16]));
		end
		check("cd_present", 64'(cd_present), 64'(r.exp_present));
		check("cd_from_card", 64'(cd_from_card), 64'(r.exp_from_card));
		if (r.exp_present) check("cd_size", 64'(cd_size), 64'(r.exp_size));
		check("card1_available", 64'(card1_available), 64'(r.exp_cards[0]));
		check("card2_available", 64'(card2_available), 64'(r.exp_cards[1]));
		check("exe_start pulses", 64'(counts[0] - snap[0]), 64'(r.exp_exe));
		check("card1_load pulses", 64'(counts[1] - snap[1]), 64'(r.exp_c1));
		check("card2_load pulses", 64'(counts[2] - snap[2]), 64'(r.exp_c2));
		check("card_save pulses", 64'(counts[3] - snap[3]), 64'(r.exp_save));
		$display("Test %0d %s: %s", n, r.op.name(), errors == err_before ? "ok" : "mismatch");
	endtask

	// ==============================
	// Stimulus table and run
	// ==============================
	initial begin
		int total;
		rst = 1'b1;
		host_dl = '0;
		sys_wr = '0;
		sys_valid = 1'b0;
		mount = '0;
		bk_load = 1'b0;
		bk_save = 1'b0;
		bk_autosave = 1'b0;
		osd_status = 1'b0;
		rows[0]  = '{OP_DL, 8'd0, 8'd4, 32'hB105_0000,
			1'b0, 1'b0, 30'd0, 2'b00, 2'd0, 2'd0, 2'd0, 2'd0};
		rows[1]  = '{OP_DL, 8'd1, 8'd3, 32'hE0E0_1000,
			1'b0, 1'b0, 30'd0, 2'b00, 2'd1, 2'd0, 2'd0, 2'd0};
		rows[2]  = '{OP_DL, 8'd2, 8'd5, 32'hCD00_0000,
			1'b1, 1'b0, 30'd18, 2'b00, 2'd0, 2'd0, 2'd0, 2'd0};
		rows[3]  = '{OP_SYS, 8'd0, 8'd1, 32'h5A5A_A5A5,
			1'b1, 1'b0, 30'd18, 2'b00, 2'd0, 2'd0, 2'd0, 2'd0};
		rows[4]  = '{OP_MOUNT, 8'd1, 8'd0, 32'h0004_B000,
			1'b1, 1'b1, 30'h4_B000, 2'b00, 2'd0, 2'd0, 2'd0, 2'd0};
		rows[5]  = '{OP_MOUNT, 8'd1, 8'd0, 32'h0,
			1'b0, 1'b1, 30'd0, 2'b00, 2'd0, 2'd0, 2'd0, 2'd0};
		rows[6]  = '{OP_MOUNT, 8'd2, 8'd0, 32'h0002_0000,
			1'b0, 1'b1, 30'd0, 2'b01, 2'd0, 2'd1, 2'd0, 2'd0};
		rows[7]  = '{OP_MOUNT, 8'd3, 8'd0, 32'h0001_0000,
			1'b0, 1'b1, 30'd0, 2'b11, 2'd0, 2'd0, 2'd1, 2'd0};
		rows[8]  = '{OP_BKLOAD, 8'd0, 8'd0, 32'h0,
			1'b0, 1'b1, 30'd0, 2'b11, 2'd0, 2'd1, 2'd1, 2'd0};
		rows[9]  = '{OP_BKSAVE, 8'd0, 8'd0, 32'h0,
			1'b0, 1'b1, 30'd0, 2'b11, 2'd0, 2'd0, 2'd0, 2'd1};
		rows[10] = '{OP_AUTOSAVE, 8'd0, 8'd0, 32'h0,
			1'b0, 1'b1, 30'd0, 2'b11, 2'd0, 2'd0, 2'd0, 2'd1};
		rows[11] = '{OP_DL, 8'd250, 8'd1, 32'h7E57_C0DE,
			1'b0, 1'b1, 30'd0, 2'b11, 2'd0, 2'd0, 2'd0, 2'd0};
		rows[12] = '{OP_DL, 8'd0, 8'd6, 32'h0BAD_F00D,
			1'b0, 1'b1, 30'd0, 2'b11, 2'd0, 2'd0, 2'd0, 2'd0};
		total = 0;
		foreach (rows[i]) total += int'(rows[i].words);
		limit = 20 * total + 200;
		repeat (16) @(posedge clk_1x);
		#2;
		rst = 1'b0;
		foreach (rows[i]) begin
			snap = counts;
			apply_row(rows[i]);
			check_row(i, rows[i]);
		end
		$display("Tests run: %0d, checks: %0d, errors: %0d", NUM_ROWS, checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* psx_loader_properties.sv */
/*
 Concurrent checks on the loader handshakes. Bound into the RAM write
 arbiter and the download packer for the request rules, and into the
 download decoder for the executable start pulse. Unused inputs of an
 instance are tied low.
*/
`timescale 1ns/10ps
`default_nettype none

module psx_loader_properties (
	input  wire logic                     clk_1x,
	input  wire logic                     rst,
	input  wire logic                     valid,
	input  wire logic                     ready,
	input  wire psx_loader_pkg::ram_wr_s  payload,
	input  wire logic                     wr,
	input  wire logic                     wait_line,
	input  wire logic                     download,
	input  wire logic                     pulse
);

	// Request and payload held until accepted
	property hold_until_ready;
		@(posedge clk_1x) disable iff (rst)
		valid && !ready |=> valid && $stable(payload);
	endproperty

	// Host stays quiet while stalled
	property no_wr_while_wait;
		@(posedge clk_1x) disable iff (rst)
		wr |-> !wait_line;
	endproperty

	// Start pulse two cycles after the download falls, so it lasts one cycle
	property pulse_after_fall;
		@(posedge clk_1x) disable iff (rst)
		pulse |-> $past(download, 3) && !$past(download, 2);
	endproperty

	a_hold: assert property (hold_until_ready)
		else $error("valid dropped or payload changed before ready");
	a_wait: assert property (no_wr_while_wait)
		else $error("host wr issued while host_wait is high");
	a_pulse: assert property (pulse_after_fall)
		else $error("pulse not a single cycle two cycles after download fell");

endmodule

bind ram_write_arbiter psx_loader_properties u_ram_props (
	.clk_1x(clk_1x), .rst(rst), .valid(ram_valid), .ready(ram_ready), .payload(ram_wr),
	.wr(1'b0), .wait_line(1'b0), .download(1'b0), .pulse(1'b0)
);

bind download_packer psx_loader_properties u_dl_props (
	.clk_1x(clk_1x), .rst(rst), .valid(dl_valid), .ready(dl_ready), .payload(dl_wr),
	.wr(host_dl.wr), .wait_line(host_wait), .download(1'b0), .pulse(1'b0)
);

bind download_decoder psx_loader_properties u_exe_props (
	.clk_1x(clk_1x), .rst(rst), .valid(1'b0), .ready(1'b0), .payload('0),
	.wr(1'b0), .wait_line(1'b0), .download(host_dl.download), .pulse(exe_start)
);

`default_nettype wire

/* psx_loader_top.sv */
/*
 Loader and media front end. Decodes host downloads, packs them into
 RAM writes that share the RAM write port with the system, and
 tracks the CD and memory-card images.
*/
`timescale 1ns/10ps
`default_nettype none

module psx_loader_top (
	input  wire logic                     clk_1x,
	input  wire logic                     rst,
	input  wire psx_loader_pkg::host_dl_s host_dl,
	output logic                          host_wait,
	input  wire psx_loader_pkg::ram_wr_s  sys_wr,
	input  wire logic                     sys_valid,
	output logic                          sys_ready,
	output psx_loader_pkg::ram_wr_s       ram_wr,
	output logic                          ram_valid,
	input  wire logic                     ram_ready,
	input  wire psx_loader_pkg::mount_s   mount,
	input  wire logic                     bk_load,
	input  wire logic                     bk_save,
	input  wire logic                     bk_autosave,
	input  wire logic                     osd_status,
	output logic                          exe_start,
	output psx_loader_pkg::half_word_t    sbi_key,
	output logic                          cd_present,
	output logic                          cd_from_card,
	output psx_loader_pkg::cd_size_t      cd_size,
	output logic                          card1_available,
	output logic                          card2_available,
	output logic                          card1_load,
	output logic                          card2_load,
	output logic                          card_save
);
	import psx_loader_pkg::*;

	dl_kind_e  kind;
	logic      cd_end;
	ram_addr_t cd_end_addr;
	ram_wr_s   dl_wr;
	logic      dl_valid;
	logic      dl_ready;

	download_decoder u_decoder (
		.clk_1x(clk_1x), .rst(rst), .host_dl(host_dl), .kind(kind),
		.exe_start(exe_start), .cd_end(cd_end), .cd_end_addr(cd_end_addr),
		.sbi_key(sbi_key)
	);

	download_packer u_packer (
		.clk_1x(clk_1x), .rst(rst), .host_dl(host_dl), .kind(kind), .dl_wr(dl_wr),
		.dl_valid(dl_valid), .dl_ready(dl_ready), .host_wait(host_wait)
	);

	ram_write_arbiter u_arbiter (
		.clk_1x(clk_1x), .rst(rst), .dl_wr(dl_wr), .dl_valid(dl_valid),
		.dl_ready(dl_ready), .sys_wr(sys_wr), .sys_valid(sys_valid),
		.sys_ready(sys_ready), .ram_wr(ram_wr), .ram_valid(ram_valid),
		.ram_ready(ram_ready)
	);

	media_mount_tracker u_media (
		.clk_1x(clk_1x), .rst(rst), .mount(mount), .cd_end(cd_end),
		.cd_end_addr(cd_end_addr), .bk_load(bk_load), .bk_save(bk_save),
		.bk_autosave(bk_autosave), .osd_status(osd_status),
		.cd_present(cd_present), .cd_from_card(cd_from_card), .cd_size(cd_size),
		.card1_available(card1_available), .card2_available(card2_available),
		.card1_load(card1_load), .card2_load(card2_load), .card_save(card_save)
	);

endmodule

`default_nettype wire

/* media_mount_tracker.sv */
/*
 Keeps the state of the CD image and of the two memory-card images.
 A CD comes either from a mounted image file or from a finished CD
 download. Card mounts and the backup load, save and autosave
 controls turn into one-cycle load and save requests.
*/
`timescale 1ns/10ps
`default_nettype none
`include "psx_loader_macros.svh"

module media_mount_tracker (
	input  wire logic                       clk_1x,
	input  wire logic                       rst,
	input  wire psx_loader_pkg::mount_s     mount,
	input  wire logic                       cd_end,
	input  wire psx_loader_pkg::ram_addr_t  cd_end_addr,
	input  wire logic                       bk_load,
	input  wire logic                       bk_save,
	input  wire logic                       bk_autosave,
	input  wire logic                       osd_status,
	output logic                            cd_present,
	output logic                            cd_from_card,
	output psx_loader_pkg::cd_size_t        cd_size,
	output logic                            card1_available,
	output logic                            card2_available,
	output logic                            card1_load,
	output logic                            card2_load,
	output logic                            card_save
);
	import psx_loader_pkg::*;

	logic mount_sized;
	logic bk_save_auto;
	logic bk_load_q;
	logic bk_save_q;
	logic bk_save_auto_q;

	assign mount_sized  = (mount.size != '0);
	// Autosave fires when the OSD opens
	assign bk_save_auto = osd_status && bk_autosave;

	// ==============================
	// Image state and requests
	// ==============================
	always_ff @(posedge clk_1x) begin
		if (rst) begin
			cd_present      <= 1'b0;
			cd_from_card    <= 1'b0;
			card1_available <= 1'b0;
			card2_available <= 1'b0;
			card1_load      <= 1'b0;
			card2_load      <= 1'b0;
			card_save       <= 1'b0;
			bk_load_q       <= 1'b0;
			bk_save_q       <= 1'b0;
			bk_save_auto_q  <= 1'b0;
		end else begin
			card1_load     <= 1'b0;
			card2_load     <= 1'b0;
			card_save      <= 1'b0;
			bk_load_q      <= bk_load;
			bk_save_q      <= bk_save;
			bk_save_auto_q <= bk_save_auto;

			if (cd_end) begin
				cd_present   <= 1'b1;
				cd_from_card <= 1'b0;
			end
			// CD image mount takes precedence over a download end
			if (mount.mounted[1]) begin
				cd_present <= mount_sized;
				if (mount_sized) begin
					cd_from_card <= 1'b1;
				end
			end
			// Slot 2 holds card 1, slot 3 card 2
			if (mount.mounted[2]) begin
				card1_available <= mount_sized;
				card1_load      <= mount_sized;
			end
			if (mount.mounted[3]) begin
				card2_available <= mount_sized;
				card2_load      <= mount_sized;
			end

			if (bk_load && !bk_load_q) begin
				card1_load <= 1'b1;
				card2_load <= 1'b1;
			end
			if ((bk_save && !bk_save_q) || (bk_save_auto && !bk_save_auto_q)) begin
				card_save <= 1'b1;
			end
		end
	end

	// CD size
	always_ff @(posedge clk_1x) begin
		if (mount.mounted[1] && mount_sized) begin
			cd_size <= mount.size[`PSX_CD_SIZE_W-1:0];
		end else if (cd_end) begin
			cd_size <= cd_size_t'(cd_end_addr);
		end
	end

endmodule

`default_nettype wire

/* ram_write_arbiter.sv */
/*
 Shares the main RAM write port between the downloader and the
 running system. Payload and valid pass through with no latency.
 An idle port goes to the downloader first, and a granted source
 keeps the port until its write is accepted.
*/
`timescale 1ns/10ps
`default_nettype none

module ram_write_arbiter (
	input  wire logic                     clk_1x,
	input  wire logic                     rst,
	input  wire psx_loader_pkg::ram_wr_s  dl_wr,
	input  wire logic                     dl_valid,
	output logic                          dl_ready,
	input  wire psx_loader_pkg::ram_wr_s  sys_wr,
	input  wire logic                     sys_valid,
	output logic                          sys_ready,
	output psx_loader_pkg::ram_wr_s       ram_wr,
	output logic                          ram_valid,
	input  wire logic                     ram_ready
);
	import psx_loader_pkg::*;

	typedef enum logic [1:0] {
		OWN_IDLE,
		OWN_DL,
		OWN_SYS
	} owner_e;

	owner_e owner;
	owner_e grant;

	// Locked owner wins, otherwise downloader before system
	always_comb begin
		grant = owner;
		if (owner == OWN_IDLE) begin
			if (dl_valid) begin
				grant = OWN_DL;
			end else if (sys_valid) begin
				grant = OWN_SYS;
			end
		end
	end

	assign ram_wr    = (grant == OWN_SYS) ? sys_wr : dl_wr;
	assign ram_valid = ((grant == OWN_DL) && dl_valid) || ((grant == OWN_SYS) && sys_valid);
	assign dl_ready  = (grant == OWN_DL) && ram_ready;
	assign sys_ready = (grant == OWN_SYS) && ram_ready;

	// Release on the accepting edge
	always_ff @(posedge clk_1x) begin
		if (rst) begin
			owner <= OWN_IDLE;
		end else if (ram_valid && ram_ready) begin
			owner <= OWN_IDLE;
		end else begin
			owner <= grant;
		end
	end

endmodule

`default_nettype wire

/* download_packer.sv */
/*
 Packs the host's 16-bit download words into 32-bit RAM writes.
 The low half sets the address, with the region offset of the
 current download kind added. The high half completes the word and
 raises the write request, and the host is held on its wait line
 until the RAM side accepts the word.
*/
`timescale 1ns/10ps
`default_nettype none
`include "psx_loader_macros.svh"

module download_packer (
	input  wire logic                      clk_1x,
	input  wire logic                      rst,
	input  wire psx_loader_pkg::host_dl_s  host_dl,
	input  wire psx_loader_pkg::dl_kind_e  kind,
	output psx_loader_pkg::ram_wr_s        dl_wr,
	output logic                           dl_valid,
	input  wire logic                      dl_ready,
	output logic                           host_wait
);
	import psx_loader_pkg::*;

	ram_addr_t region_base;
	logic      ram_kind;
	logic      low_wr;
	logic      high_wr;

	// ==============================
	// Region decode
	// ==============================
	always_comb begin
		case (kind)
			DL_BIOS: region_base = `PSX_BIOS_BASE;
			DL_EXE:  region_base = `PSX_EXE_BASE;
			default: region_base = '0;
		endcase
	end

	// Only BIOS, executable and CD data go to RAM
	assign ram_kind = (kind == DL_BIOS) || (kind == DL_EXE) || (kind == DL_CD);
	assign low_wr   = ram_kind && host_dl.wr && !host_dl.addr[1];
	assign high_wr  = ram_kind && host_dl.wr && host_dl.addr[1];

	// ==============================
	// Word assembly
	// ==============================
	always_ff @(posedge clk_1x) begin
		if (low_wr) begin
			dl_wr.addr                    <= host_dl.addr + region_base;
			dl_wr.data[`PSX_HALF_W-1:0]   <= host_dl.data;
		end
		if (high_wr) begin
			dl_wr.data[`PSX_WORD_W-1:`PSX_HALF_W] <= host_dl.data;
			dl_wr.be                              <= '1;
		end
	end

	// ==============================
	// Request and host stall
	// ==============================
	always_ff @(posedge clk_1x) begin
		if (rst) begin
			dl_valid  <= 1'b0;
			host_wait <= 1'b0;
		end else begin
			if (dl_valid && dl_ready) begin
				dl_valid  <= 1'b0;
				host_wait <= 1'b0;
			end
			if (high_wr) begin
				dl_valid  <= 1'b1;
				host_wait <= 1'b1;
			end
			// Host released once the download is over
			if (!ram_kind) begin
				host_wait <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* download_decoder.sv */
/*
 Decodes the host download index into a registered download kind.
 Watches the kind for the end of an executable or CD download and
 emits one-cycle events for them, and captures the protection key
 written during an sbi download.
*/
`timescale 1ns/10ps
`default_nettype none
`include "psx_loader_macros.svh"

module download_decoder (
	input  wire logic                      clk_1x,
	input  wire logic                      rst,
	input  wire psx_loader_pkg::host_dl_s  host_dl,
	output psx_loader_pkg::dl_kind_e       kind,
	output logic                           exe_start,
	output logic                           cd_end,
	output psx_loader_pkg::ram_addr_t      cd_end_addr,
	output psx_loader_pkg::half_word_t     sbi_key
);
	import psx_loader_pkg::*;

	dl_kind_e kind_next;
	dl_kind_e kind_prev;
	logic     exe_done;
	logic     cd_done;

	// Index to kind
	always_comb begin
		kind_next = DL_NONE;
		if (host_dl.download) begin
			if (host_dl.index == `PSX_IDX_BIOS) begin
				kind_next = DL_BIOS;
			end else if (host_dl.index == `PSX_IDX_EXE) begin
				kind_next = DL_EXE;
			end else if (host_dl.index[5:0] == `PSX_IDX_CD) begin
				kind_next = DL_CD;
			end else if (host_dl.index == `PSX_IDX_SBI) begin
				kind_next = DL_SBI;
			end
		end
	end

	// A kind that was active and is gone now
	assign exe_done = (kind_prev == DL_EXE) && (kind != DL_EXE);
	assign cd_done  = (kind_prev == DL_CD) && (kind != DL_CD);

	always_ff @(posedge clk_1x) begin
		if (rst) begin
			kind      <= DL_NONE;
			kind_prev <= DL_NONE;
			exe_start <= 1'b0;
			cd_end    <= 1'b0;
		end else begin
			kind      <= kind_next;
			kind_prev <= kind;
			exe_start <= exe_done;
			cd_end    <= cd_done;
		end
	end

	// Last host address gives the CD image size
	always_ff @(posedge clk_1x) begin
		if (cd_done) begin
			cd_end_addr <= host_dl.addr;
		end
		if (kind == DL_SBI && host_dl.wr) begin
			sbi_key <= host_dl.data;
		end
	end

endmodule

`default_nettype wire

/* psx_loader_pkg.sv */
/*
 Types of the loader front end: meaningful vector widths, the
 download kind and the bundles that travel between the blocks.
 Modules import it inside their bodies.
*/
`default_nettype none
`include "psx_loader_macros.svh"

package psx_loader_pkg;

	typedef logic [`PSX_ADDR_W-1:0]    ram_addr_t;
	typedef logic [`PSX_HALF_W-1:0]    half_word_t;
	typedef logic [`PSX_WORD_W-1:0]    ram_word_t;
	typedef logic [`PSX_CD_SIZE_W-1:0] cd_size_t;
	typedef logic [7:0]                dl_index_t;

	typedef enum logic [2:0] {
		DL_NONE,
		DL_BIOS,
		DL_EXE,
		DL_CD,
		DL_SBI
	} dl_kind_e;

	// Host download bus
	typedef struct packed {
		logic       download;
		dl_index_t  index;
		ram_addr_t  addr;
		half_word_t data;
		logic       wr;
	} host_dl_s;

	// One 32-bit RAM write
	typedef struct packed {
		ram_addr_t  addr;
		ram_word_t  data;
		logic [3:0] be;
	} ram_wr_s;

	// Slot 1 is the CD, slots 2 and 3 the memory cards
	typedef struct packed {
		logic [3:0]  mounted;
		logic [63:0] size;
	} mount_s;

endpackage

`default_nettype wire

/* psx_loader_macros.svh */
/*
 Widths, RAM region offsets and host download indices shared by the
 loader front end. Included by the package and by every module that
 compares download indices or adds a region offset.
*/
`ifndef PSX_LOADER_MACROS_SVH
`define PSX_LOADER_MACROS_SVH

// Bus widths
`define PSX_ADDR_W    27
`define PSX_HALF_W    16
`define PSX_WORD_W    32
`define PSX_CD_SIZE_W 30

// RAM offsets of the loaded regions
`define PSX_BIOS_BASE 27'h020_0000
`define PSX_EXE_BASE  27'h040_0000

// Host download indices
// CD is matched on the low 6 bits only
`define PSX_IDX_BIOS 8'd0
`define PSX_IDX_EXE  8'd1
`define PSX_IDX_CD   6'd2
`define PSX_IDX_SBI  8'd250

`endif
